/* timer_a.f */
rtl/timer_a_pkg.sv
rtl/timer_a_regs.sv
rtl/timer_a_counter.sv
rtl/timer_a_ccr.sv
rtl/timer_a.sv
verification/timer_a_clkgen.sv
verification/timer_a_tb.sv

/* Bender.yml */
package:
  name: timer_a

sources:
  - rtl/timer_a_pkg.sv
  - rtl/timer_a_regs.sv
  - rtl/timer_a_counter.sv
  - rtl/timer_a_ccr.sv
  - rtl/timer_a.sv
  - target: test
    files:
      - verification/timer_a_clkgen.sv
      - verification/timer_a_tb.sv

/* verification/timer_a_tb.sv */
//////////////////////////////////////////////////////////////////////
// Timer A testbench
// Directed tests over the peripheral bus, one task per behavior,
// with a watchdog bounding the run
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module timer_a_tb import timer_a_pkg::*; ();

  localparam int          CLK_PERIOD      = 40;
  localparam int          DRIVE_DLY       = 1;     // After rising edge
  localparam int          WATCHDOG_CYCLES = 2000;  // Tests need roughly 350
  localparam int          POLL_LIMIT      = 50;
  localparam logic [31:0] SEED            = 32'h1170_860c;

  // Writable fields by the register layout
  localparam logic [15:0] CTL_MASK  = 16'h03F2;  // TASSEL, ID, MC, TAIE
  localparam logic [15:0] CCTL_MASK = 16'h00F4;  // OUTMOD, CCIE, OUT
  localparam logic [15:0] MC_BITS   = 16'h0030;
  localparam logic [15:0] CCIE      = 16'h0010;
  localparam logic [15:0] OUT_BIT   = 16'h0004;

  logic        mclk;
  logic        puc_rst;
  per_req_t    per;
  logic [15:0] per_dout;
  logic        aclk_en;
  logic        smclk_en;
  logic        irq_ta0_acc;
  logic        irq_ta0;
  logic        irq_ta1;
  logic        ta_out0;
  logic        ta_out1;

  int   aclk_cnt;   // ACLK prescale, one pulse every third cycle
  int   aclk_seen;  // Pulses sampled by the DUT so far
  logic rd_irq1;    // Snapshots taken with each read
  logic rd_out1;
  int   rd_aclk;

  timer_a_clkgen clkgen_i (
    .mclk    (mclk),
    .puc_rst (puc_rst)
  );

  timer_a dut_i (
    .mclk        (mclk),
    .puc_rst     (puc_rst),
    .per         (per),
    .per_dout    (per_dout),
    .aclk_en     (aclk_en),
    .smclk_en    (smclk_en),
    .irq_ta0_acc (irq_ta0_acc),
    .irq_ta0     (irq_ta0),
    .irq_ta1     (irq_ta1),
    .ta_out0     (ta_out0),
    .ta_out1     (ta_out1)
  );

  always @(posedge mclk) begin
    #DRIVE_DLY;
    aclk_cnt = (aclk_cnt == 2) ? 0 : aclk_cnt + 1;
    aclk_en  = (aclk_cnt == 0);
  end

  always @(posedge mclk) begin
    if (aclk_en) aclk_seen = aclk_seen + 1;  // Stable, driver waits 1 ns
  end

  //////////////////////////////////////////////////////////////////////
  // Reporting and helpers
  //////////////////////////////////////////////////////////////////////
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic stop_on_error(input string msg);
    abort_run($sformatf("Fail at %0t ns: %s", $time, msg));
  endtask

  task automatic check_value(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got === exp)
      else stop_on_error($sformatf("%s is 0x%04h, expected 0x%04h", what, got, exp));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    assert (got === exp)
      else stop_on_error($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  // Byte offset inside the timer window to bus word address
  function automatic logic [13:0] word_addr(input logic [DEC_WD-1:0] ofs);
    logic [14:0] byte_addr;
    byte_addr = BASE_ADDR + {8'h00, ofs};
    return byte_addr[14:1];
  endfunction

  function automatic logic [15:0] tactl_word(input logic [1:0] sel, input logic [1:0] id,
                                             input logic [1:0] mc, input logic taie,
                                             input logic clr);
    return {6'b0, sel, id, mc, 1'b0, clr, taie, 1'b0};
  endfunction

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge mclk);
      #DRIVE_DLY;
    end
  endtask

  task automatic bus_write(input logic [DEC_WD-1:0] ofs, input logic [15:0] data);
    per.en   = 1'b1;
    per.addr = word_addr(ofs);
    per.we   = 2'b11;
    per.din  = data;
    @(posedge mclk);
    #DRIVE_DLY;
    per = '0;
  endtask

  // Read data is combinational, sampled mid-cycle
  task automatic bus_read(input logic [DEC_WD-1:0] ofs, output logic [15:0] data);
    per.en   = 1'b1;
    per.addr = word_addr(ofs);
    per.we   = 2'b00;
    per.din  = 16'h0000;
    @(negedge mclk);
    data    = per_dout;
    rd_irq1 = irq_ta1;
    rd_out1 = ta_out1;
    rd_aclk = aclk_seen;
    @(posedge mclk);
    #DRIVE_DLY;
    per = '0;
  endtask

  task automatic write_read_check(input string what, input logic [DEC_WD-1:0] ofs,
                                  input logic [15:0] data, input logic [15:0] mask);
    logic [15:0] rdata;
    bus_write(ofs, data);
    bus_read(ofs, rdata);
    check_value(what, rdata, data & mask);
  endtask

  task automatic pulse_ta0_ack();
    irq_ta0_acc = 1'b1;
    @(posedge mclk);
    #DRIVE_DLY;
    irq_ta0_acc = 1'b0;
  endtask

  // Stop the timer and drain every flag through TAIV and the ack line
  task automatic clear_all_flags();
    logic [15:0] rdata;
    bus_write(TACTL_OFS, tactl_word(2'b00, 2'd0, MC_STOP, 1'b1, 1'b0));
    bus_write(TACCTL1_OFS, CCIE);
    bus_read(TAIV_OFS, rdata);  // CCR1 if pending
    bus_read(TAIV_OFS, rdata);  // Then TAIFG
    bus_write(TACCTL0_OFS, 16'h0000);
    bus_write(TACCTL1_OFS, 16'h0000);
    bus_write(TACTL_OFS, tactl_word(2'b00, 2'd0, MC_STOP, 1'b0, 1'b1));
    pulse_ta0_ack();
    bus_read(TACTL_OFS, rdata);
    check_value("TACTL after flag clear", rdata, 16'h0000);
    bus_read(TACCTL0_OFS, rdata);
    check_value("TACCTL0 after flag clear", rdata, 16'h0000);
    bus_read(TACCTL1_OFS, rdata);
    check_value("TACCTL1 after flag clear", rdata, 16'h0000);
    check_bit("irq_ta0 after flag clear", irq_ta0, 1'b0);
    check_bit("irq_ta1 after flag clear", irq_ta1, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////
  task automatic readback_test();
    logic [15:0] rdata;
    check_bit("irq_ta0 after reset", irq_ta0, 1'b0);
    check_bit("irq_ta1 after reset", irq_ta1, 1'b0);
    check_bit("ta_out0 after reset", ta_out0, 1'b0);
    check_bit("ta_out1 after reset", ta_out1, 1'b0);
    bus_read(TAIV_OFS, rdata);
    check_value("TAIV after reset", rdata, 16'h0000);
    // MC kept at stop so no flag can rise
    write_read_check("TACTL", TACTL_OFS, 16'($urandom) & ~MC_BITS, CTL_MASK);
    write_read_check("TACCTL0", TACCTL0_OFS, 16'($urandom), CCTL_MASK);
    write_read_check("TACCTL1", TACCTL1_OFS, 16'($urandom), CCTL_MASK);
    write_read_check("TACCR0", TACCR0_OFS, 16'($urandom), 16'hFFFF);
    write_read_check("TACCR1", TACCR1_OFS, 16'($urandom), 16'hFFFF);
  endtask

  task automatic continuous_test();
    logic [15:0] t0;
    logic [15:0] t1;
    int          p0;
    clear_all_flags();
    bus_write(TACTL_OFS, tactl_word(SEL_SMCLK, 2'd0, MC_CONT, 1'b0, 1'b1));
    bus_read(TAR_OFS, t0);
    idle_cycles(9);
    bus_read(TAR_OFS, t1);
    check_value("TAR step over 10 SMCLK cycles", t1 - t0, 16'd10);
    // ACLK divided by 8, prescaler restarted by TACLR
    bus_write(TACTL_OFS, tactl_word(SEL_ACLK, 2'd3, MC_CONT, 1'b0, 1'b1));
    p0 = aclk_seen;
    idle_cycles(100);
    bus_read(TAR_OFS, t1);
    check_value("TAR on ACLK/8", t1, 16'((rd_aclk - p0) / 8));
    bus_write(TACTL_OFS, tactl_word(SEL_SMCLK, 2'd0, MC_CONT, 1'b0, 1'b1));
    bus_read(TAR_OFS, t1);
    check_value("TAR after TACLR", t1, 16'h0000);
  endtask

  task automatic up_mode_test();
    logic [15:0] tar_val;
    logic [15:0] top;
    int          n;
    clear_all_flags();
    bus_write(TACCR0_OFS, 16'd5);
    bus_write(TACCTL0_OFS, CCIE);
    bus_write(TACTL_OFS, tactl_word(SEL_SMCLK, 2'd0, MC_UP, 1'b0, 1'b1));
    top = 16'h0000;
    repeat (18) begin
      bus_read(TAR_OFS, tar_val);
      assert (tar_val <= 16'd5)
        else stop_on_error($sformatf("TAR read 0x%04h above TACCR0 in up mode", tar_val));
      if (tar_val > top) top = tar_val;
    end
    check_value("Highest TAR in up mode", top, 16'd5);
    n = 0;
    while (!irq_ta0 && n < POLL_LIMIT) begin
      idle_cycles(1);
      n++;
    end
    assert (irq_ta0) else abort_run("Timed out waiting for irq_ta0 in up mode");
    bus_write(TACTL_OFS, tactl_word(SEL_SMCLK, 2'd0, MC_STOP, 1'b0, 1'b0));
    check_bit("irq_ta0 before ack", irq_ta0, 1'b1);
    pulse_ta0_ack();
    check_bit("irq_ta0 after ack", irq_ta0, 1'b0);
  endtask

  task automatic updown_test();
    logic [15:0] tar_val;
    logic [15:0] prev;
    logic [15:0] exp;
    logic        rising;
    logic        seen_top;
    logic        back_at_zero;
    clear_all_flags();
    bus_write(TACCR0_OFS, 16'd4);
    bus_write(TACTL_OFS, tactl_word(SEL_SMCLK, 2'd0, MC_UPDOWN, 1'b1, 1'b1));
    bus_read(TAR_OFS, prev);
    check_value("TAR at up/down start", prev, 16'h0000);
    rising       = 1'b1;
    seen_top     = 1'b0;
    back_at_zero = 1'b0;
    repeat (12) begin
      bus_read(TAR_OFS, tar_val);
      if (rising && prev == 16'd4) rising = 1'b0;       // Turn at TACCR0
      else if (!rising && prev == 16'd0) rising = 1'b1;  // Turn at zero
      exp = rising ? prev + 16'd1 : prev - 16'd1;
      check_value("TAR in up/down mode", tar_val, exp);
      if (tar_val == 16'd4) seen_top = 1'b1;
      if (seen_top && tar_val == 16'd0) back_at_zero = 1'b1;
      check_bit("irq_ta1 in up/down mode", rd_irq1, back_at_zero);
      prev = tar_val;
    end
  endtask

  task automatic taiv_priority_test();
    logic [15:0] rdata;
    int          n;
    clear_all_flags();
    bus_write(TACCR0_OFS, 16'd5);
    bus_write(TACCR1_OFS, 16'd2);
    bus_write(TACCTL1_OFS, CCIE);
    bus_write(TACTL_OFS, tactl_word(SEL_SMCLK, 2'd0, MC_UP, 1'b1, 1'b1));
    n = 0;
    bus_read(TACTL_OFS, rdata);
    while (!rdata[0] && n < POLL_LIMIT) begin
      bus_read(TACTL_OFS, rdata);
      n++;
    end
    assert (rdata[0]) else abort_run("Timed out waiting for TAIFG in up mode");
    bus_write(TACTL_OFS, tactl_word(SEL_SMCLK, 2'd0, MC_STOP, 1'b1, 1'b0));
    bus_read(TACCTL1_OFS, rdata);
    check_bit("CCIFG1 pending", rdata[0], 1'b1);
    check_bit("irq_ta1 with both pending", irq_ta1, 1'b1);
    bus_read(TAIV_OFS, rdata);
    check_value("First TAIV read", rdata, 16'h0002);
    bus_read(TAIV_OFS, rdata);
    check_value("Second TAIV read", rdata, 16'h000A);
    bus_read(TAIV_OFS, rdata);
    check_value("Third TAIV read", rdata, 16'h0000);
    check_bit("irq_ta1 after TAIV reads", irq_ta1, 1'b0);
  endtask

  task automatic wait_ta_out0(input logic exp);
    int n;
    n = 0;
    while (ta_out0 !== exp && n < POLL_LIMIT) begin
      idle_cycles(1);
      n++;
    end
    check_bit("ta_out0 in OUT mode", ta_out0, exp);
  endtask

  task automatic output_mode_test();
    logic [15:0] tar_val;
    logic [15:0] prev;
    logic [15:0] toggles;
    logic        last_out;
    logic        exp_out;
    clear_all_flags();
    bus_write(TACCR0_OFS, 16'd5);
    bus_write(TACCR1_OFS, 16'd2);
    bus_write(TACCTL1_OFS, {8'h00, OUTMOD_TOG, 5'b00000});
    bus_write(TACTL_OFS, tactl_word(SEL_SMCLK, 2'd0, MC_UP, 1'b0, 1'b1));
    bus_read(TAR_OFS, prev);
    last_out = rd_out1;
    toggles  = 16'd0;
    repeat (18) begin
      bus_read(TAR_OFS, tar_val);
      exp_out = (prev == 16'd1 && tar_val == 16'd2) ? ~last_out : last_out;  // Lands on TACCR1
      check_bit("ta_out1 in toggle mode", rd_out1, exp_out);
      if (rd_out1 != last_out) toggles = toggles + 16'd1;
      last_out = rd_out1;
      prev     = tar_val;
    end
    check_value("ta_out1 toggles in three periods", toggles, 16'd3);
    // Plain OUT mode on channel 0, timer stopped
    bus_write(TACTL_OFS, tactl_word(2'b00, 2'd0, MC_STOP, 1'b0, 1'b1));
    bus_write(TACCTL0_OFS, {8'h00, OUTMOD_OUT, 5'b00000} | OUT_BIT);
    wait_ta_out0(1'b1);
    bus_write(TACCTL0_OFS, 16'h0000);
    wait_ta_out0(1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    per         = '0;
    aclk_en     = 1'b0;
    smclk_en    = 1'b1;  // SMCLK runs at mclk rate
    irq_ta0_acc = 1'b0;
    aclk_cnt    = 0;
    aclk_seen   = 0;
    @(negedge puc_rst);
    @(posedge mclk);
    #DRIVE_DLY;
    readback_test();
    continuous_test();
    up_mode_test();
    updown_test();
    taiv_priority_test();
    output_mode_test();
    $display("Everything OK");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("Watchdog expired before the tests finished");
  end

endmodule

/* verification/timer_a_clkgen.sv */
//////////////////////////////////////////////////////////////////////
// Timer A testbench clock and reset
// 40 ns mclk, puc_rst held for the first two cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module timer_a_clkgen (
  output logic mclk,
  output logic puc_rst
);

  localparam int PERIOD = 40;

  initial begin
    mclk = 1'b0;
    forever #(PERIOD / 2) mclk = ~mclk;
  end

  initial begin
    puc_rst = 1'b1;
    repeat (2) @(posedge mclk);
    #1;
    puc_rst = 1'b0;  // Released just after the second edge
  end

endmodule

/* rtl/timer_a.sv */
//////////////////////////////////////////////////////////////////////
// Timer A top level
// Register block, counter and compare channels 0 and 1
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module timer_a import timer_a_pkg::*; (
  input  logic        mclk,
  input  logic        puc_rst,
  input  per_req_t    per,
  output logic [15:0] per_dout,
  input  logic        aclk_en,
  input  logic        smclk_en,
  input  logic        irq_ta0_acc,  // CCR0 interrupt taken
  output logic        irq_ta0,
  output logic        irq_ta1,
  output logic        ta_out0,
  output logic        ta_out1
);

  tactl_t      tactl;
  tmr_t        tmr;
  tacctl_t     cctl0;
  tacctl_t     cctl1;
  ccr_wr_t     ccr0_wr;
  ccr_wr_t     ccr1_wr;
  logic [15:0] ccr0_val;
  logic [15:0] ccr1_val;
  logic        tar_wr;
  logic        taclr;
  logic        taifg_set;
  logic        ccifg1_clr;
  logic        equ0;

  timer_a_regs regs_i (
    .mclk       (mclk),
    .puc_rst    (puc_rst),
    .per        (per),
    .per_dout   (per_dout),
    .tmr        (tmr),
    .taifg_set  (taifg_set),
    .cctl0      (cctl0),
    .cctl1      (cctl1),
    .ccr0_val   (ccr0_val),
    .ccr1_val   (ccr1_val),
    .tactl      (tactl),
    .tar_wr     (tar_wr),
    .taclr      (taclr),
    .ccr0_wr    (ccr0_wr),
    .ccr1_wr    (ccr1_wr),
    .ccifg1_clr (ccifg1_clr),
    .irq_ta1    (irq_ta1)
  );

  timer_a_counter counter_i (
    .mclk      (mclk),
    .puc_rst   (puc_rst),
    .tactl     (tactl),
    .aclk_en   (aclk_en),
    .smclk_en  (smclk_en),
    .tar_wr    (tar_wr),
    .taclr     (taclr),
    .din       (per.din),
    .taccr0    (ccr0_val),
    .tmr       (tmr),
    .taifg_set (taifg_set)
  );

  // Channel 0, its own equ serves as both events
  timer_a_ccr ccr0_i (
    .mclk      (mclk),
    .puc_rst   (puc_rst),
    .wr        (ccr0_wr),
    .din       (per.din),
    .tmr       (tmr),
    .equ0      (equ0),
    .ccifg_clr (irq_ta0_acc),
    .cctl      (cctl0),
    .ccr       (ccr0_val),
    .equ       (equ0),
    .ta_out    (ta_out0),
    .irq       (irq_ta0)
  );

  // Channel 1, flag cleared through TAIV
  timer_a_ccr ccr1_i (
    .mclk      (mclk),
    .puc_rst   (puc_rst),
    .wr        (ccr1_wr),
    .din       (per.din),
    .tmr       (tmr),
    .equ0      (equ0),
    .ccifg_clr (ccifg1_clr),
    .cctl      (cctl1),
    .ccr       (ccr1_val),
    .equ       (),
    .ta_out    (ta_out1),
    .irq       ()           // Shared line built in regs_i
  );

endmodule

/* rtl/timer_a_ccr.sv */
//////////////////////////////////////////////////////////////////////
// Timer A compare channel
// TACCTLx, TACCRx, equality detect, CCIFG and the output unit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module timer_a_ccr import timer_a_pkg::*; (
  input  logic        mclk,
  input  logic        puc_rst,
  input  ccr_wr_t     wr,
  input  logic [15:0] din,
  input  tmr_t        tmr,
  input  logic        equ0,       // Second event for dual modes
  input  logic        ccifg_clr,
  output tacctl_t     cctl,
  output logic [15:0] ccr,
  output logic        equ,
  output logic        ta_out,
  output logic        irq
);

  logic ccifg_set;
  logic out_nxt;

  // Hit on the pulse that lands on TACCRx, once only
  assign equ       = (tmr.tar_nxt == ccr) & (tmr.tar != ccr);
  assign ccifg_set = tmr.tar_clk & tmr.running & equ;
  assign irq       = cctl.ccifg & cctl.ccie;

  //////////////////////////////////////////////////////////////////////
  // Control and compare registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      cctl <= '0;
    end else begin
      if (wr.cctl_wr) begin
        cctl <= tacctl_t'(din & TACCTL_WMASK);
      end
      if (ccifg_set) begin
        cctl.ccifg <= 1'b1;
      end else if (ccifg_clr) begin
        cctl.ccifg <= 1'b0;
      end else begin
        cctl.ccifg <= cctl.ccifg;  // Not software writable
      end
    end
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      ccr <= 16'h0000;
    end else if (wr.ccr_wr) begin
      ccr <= din;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output unit
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (cctl.outmod)
      OUTMOD_OUT:     out_nxt = cctl.out;
      OUTMOD_SET:     out_nxt = equ ? 1'b1 : ta_out;
      OUTMOD_TOG_RST: out_nxt = equ ? ~ta_out : (equ0 ? 1'b0 : ta_out);
      OUTMOD_SET_RST: out_nxt = equ ? 1'b1 : (equ0 ? 1'b0 : ta_out);
      OUTMOD_TOG:     out_nxt = equ ? ~ta_out : ta_out;
      OUTMOD_RST:     out_nxt = equ ? 1'b0 : ta_out;
      OUTMOD_TOG_SET: out_nxt = equ ? ~ta_out : (equ0 ? 1'b1 : ta_out);
      default:        out_nxt = equ ? 1'b0 : (equ0 ? 1'b1 : ta_out);  // Reset/set
    endcase
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      ta_out <= 1'b0;
    end else if ((cctl.outmod == OUTMOD_OUT) | tmr.tar_clk) begin
      ta_out <= out_nxt;           // OUT mode follows the bit even when stopped
    end
  end

  // Compare event must not be lost to a same-cycle acknowledge
  a_set_wins: assert property (@(posedge mclk) disable iff (puc_rst)
    (ccifg_set & ccifg_clr) |=> cctl.ccifg);

endmodule

/* rtl/timer_a_counter.sv */
//////////////////////////////////////////////////////////////////////
// Timer A counter
// Clock source select, input divider, TAR and up/down direction
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module timer_a_counter import timer_a_pkg::*; (
  input  logic        mclk,
  input  logic        puc_rst,
  input  tactl_t      tactl,
  input  logic        aclk_en,    // ACLK enable pulse
  input  logic        smclk_en,   // SMCLK enable pulse
  input  logic        tar_wr,
  input  logic        taclr,
  input  logic [15:0] din,
  input  logic [15:0] taccr0,     // Period in up and up/down
  output tmr_t        tmr,
  output logic        taifg_set
);

  logic        sel_clk;
  logic        div_done;
  logic [2:0]  clk_div;
  logic        running;
  logic        tar_clk;
  logic        tar_clr;
  logic        tar_inc;
  logic        tar_dec;
  logic        tar_dir;   // 1 while falling in up/down
  logic [15:0] tar_q;
  logic [15:0] tar_add;
  logic [15:0] tar_nxt;

  //////////////////////////////////////////////////////////////////////
  // Clock select and divider
  //////////////////////////////////////////////////////////////////////
  // Codes 00 and 11 give no pulses
  assign sel_clk = (tactl.tassel == SEL_ACLK)  ? aclk_en  :
                   (tactl.tassel == SEL_SMCLK) ? smclk_en :
                                                 1'b0;

  assign running = (tactl.mc != MC_STOP);

  // 1, 2, 4 or 8 source enables per pulse
  always_comb begin
    case (tactl.id)
      2'd0:    div_done = 1'b1;
      2'd1:    div_done = clk_div[0];
      2'd2:    div_done = &clk_div[1:0];
      default: div_done = &clk_div[2:0];
    endcase
  end

  assign tar_clk = running & sel_clk & div_done;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      clk_div <= 3'd0;
    end else if (tar_clk | taclr) begin
      clk_div <= 3'd0;             // Restart prescale
    end else if (running & sel_clk) begin
      clk_div <= clk_div + 3'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Count control
  //////////////////////////////////////////////////////////////////////
  assign tar_clr = ((tactl.mc == MC_UP) & (tar_q >= taccr0)) |
                   ((tactl.mc == MC_UPDOWN) & (taccr0 == 16'h0000));

  // Turn around at the top in up/down
  assign tar_dec = tar_dir | ((tactl.mc == MC_UPDOWN) & (tar_q >= taccr0));
  assign tar_inc = (tactl.mc == MC_UP) | (tactl.mc == MC_CONT) |
                   ((tactl.mc == MC_UPDOWN) & ~tar_dec);

  assign tar_add = tar_inc ? 16'h0001 :
                   tar_dec ? 16'hFFFF :  // Minus one
                             16'h0000;
  assign tar_nxt = tar_clr ? 16'h0000 : (tar_q + tar_add);

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tar_dir <= 1'b0;
    end else if (taclr | (tactl.mc != MC_UPDOWN)) begin
      tar_dir <= 1'b0;
    end else if (tar_clk & (tar_q == 16'h0001)) begin
      tar_dir <= 1'b0;             // Bottom reached, go up again
    end else if (tar_q >= taccr0) begin
      tar_dir <= 1'b1;
    end
  end

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tar_q <= 16'h0000;
    end else if (tar_wr) begin
      tar_q <= din;
    end else if (taclr) begin
      tar_q <= 16'h0000;
    end else if (tar_clk) begin
      tar_q <= tar_nxt;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Overflow events and status out
  //////////////////////////////////////////////////////////////////////
  assign taifg_set = tar_clk &
                     (((tactl.mc == MC_UP) & (tar_q == taccr0)) |
                      ((tactl.mc == MC_CONT) & (tar_q == 16'hFFFF)) |
                      ((tactl.mc == MC_UPDOWN) & tar_dec & (tar_nxt == 16'h0000)));

  assign tmr.tar     = tar_q;
  assign tmr.tar_nxt = tar_nxt;
  assign tmr.tar_clk = tar_clk;
  assign tmr.running = running;

  // Stopped timer holds its count unless software loads or clears it
  a_no_clk_stop: assert property (@(posedge mclk) disable iff (puc_rst)
    ((tactl.mc == MC_STOP) & !tar_wr & !taclr) |=> $stable(tmr.tar));

endmodule

/* rtl/timer_a_regs.sv */
//////////////////////////////////////////////////////////////////////
// Timer A register block
// Address decode, TACTL, TAIV priority encoder and read data mux
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module timer_a_regs import timer_a_pkg::*; (
  input  logic        mclk,
  input  logic        puc_rst,
  input  per_req_t    per,         // Peripheral bus request
  output logic [15:0] per_dout,    // Combinational read data
  input  tmr_t        tmr,
  input  logic        taifg_set,   // Overflow event from counter
  input  tacctl_t     cctl0,
  input  tacctl_t     cctl1,
  input  logic [15:0] ccr0_val,
  input  logic [15:0] ccr1_val,
  output tactl_t      tactl,
  output logic        tar_wr,
  output logic        taclr,       // One-cycle clear pulse
  output ccr_wr_t     ccr0_wr,
  output ccr_wr_t     ccr1_wr,
  output logic        ccifg1_clr,  // From TAIV access
  output logic        irq_ta1
);

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////
  logic              reg_sel;
  logic [DEC_WD-1:0] reg_addr;
  logic              reg_write;
  logic              reg_read;
  logic              hit_tactl;
  logic              hit_tar;
  logic              hit_cctl0;
  logic              hit_ccr0;
  logic              hit_cctl1;
  logic              hit_ccr1;
  logic              hit_taiv;
  logic              tactl_wr;

  // Upper address bits must land in our window
  assign reg_sel   = per.en & (per.addr[13:DEC_WD-1] == BASE_ADDR[14:DEC_WD]);
  assign reg_addr  = {per.addr[DEC_WD-2:0], 1'b0};  // Back to byte offset
  assign reg_write = reg_sel & (|per.we);
  assign reg_read  = reg_sel & ~(|per.we);

  assign hit_tactl = (reg_addr == TACTL_OFS);
  assign hit_tar   = (reg_addr == TAR_OFS);
  assign hit_cctl0 = (reg_addr == TACCTL0_OFS);
  assign hit_ccr0  = (reg_addr == TACCR0_OFS);
  assign hit_cctl1 = (reg_addr == TACCTL1_OFS);
  assign hit_ccr1  = (reg_addr == TACCR1_OFS);
  assign hit_taiv  = (reg_addr == TAIV_OFS);

  // Write strobes out to counter and channels
  assign tactl_wr        = reg_write & hit_tactl;
  assign taclr           = tactl_wr & per.din[TACLR_BIT];
  assign tar_wr          = reg_write & hit_tar;
  assign ccr0_wr.cctl_wr = reg_write & hit_cctl0;
  assign ccr0_wr.ccr_wr  = reg_write & hit_ccr0;
  assign ccr1_wr.cctl_wr = reg_write & hit_cctl1;
  assign ccr1_wr.ccr_wr  = reg_write & hit_ccr1;

  //////////////////////////////////////////////////////////////////////
  // TAIV and flag clears
  //////////////////////////////////////////////////////////////////////
  logic [3:0] taiv;
  logic       taiv_acc;
  logic       taifg_clr;

  // CCR1 outranks overflow
  assign taiv = (cctl1.ccifg & cctl1.ccie) ? TAIV_CCR1  :
                (tactl.taifg & tactl.taie) ? TAIV_TAIFG :
                                             TAIV_NONE;

  assign taiv_acc   = reg_sel & hit_taiv;  // Read or write both count
  assign ccifg1_clr = taiv_acc & (taiv == TAIV_CCR1);
  assign taifg_clr  = taiv_acc & (taiv == TAIV_TAIFG);

  //////////////////////////////////////////////////////////////////////
  // TACTL
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      tactl <= '0;
    end else begin
      if (tactl_wr) begin
        tactl <= tactl_t'(per.din & TACTL_WMASK);
      end
      if (taifg_set) begin
        tactl.taifg <= 1'b1;         // New event beats a pending clear
      end else if (taifg_clr) begin
        tactl.taifg <= 1'b0;
      end else begin
        tactl.taifg <= tactl.taifg;  // Survives control writes
      end
    end
  end

  assign irq_ta1 = (tactl.taifg & tactl.taie) | (cctl1.ccifg & cctl1.ccie);

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////
  assign per_dout = (tactl          & {16{reg_read & hit_tactl}}) |
                    (tmr.tar        & {16{reg_read & hit_tar}})   |
                    (cctl0          & {16{reg_read & hit_cctl0}}) |
                    (ccr0_val       & {16{reg_read & hit_ccr0}})  |
                    (cctl1          & {16{reg_read & hit_cctl1}}) |
                    (ccr1_val       & {16{reg_read & hit_ccr1}})  |
                    ({12'h000, taiv} & {16{reg_read & hit_taiv}});

  // Shared bus relies on idle slaves returning zero
  a_dout_idle: assert property (@(posedge mclk) disable iff (puc_rst)
    !reg_read |-> (per_dout == 16'h0000));

endmodule

/* rtl/timer_a_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Timer A shared definitions
// Register map, field layouts, mode codes and the bus and counter
// structs used across the timer blocks
//////////////////////////////////////////////////////////////////////

package timer_a_pkg;

  //////////////////////////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////////////////////////
  localparam logic [14:0] BASE_ADDR = 15'h0100;  // Byte base, decode aligned
  localparam int          DEC_WD    = 7;         // Local decode width

  localparam logic [DEC_WD-1:0] TACTL_OFS   = 7'h60;
  localparam logic [DEC_WD-1:0] TAR_OFS     = 7'h70;
  localparam logic [DEC_WD-1:0] TACCTL0_OFS = 7'h62;
  localparam logic [DEC_WD-1:0] TACCR0_OFS  = 7'h72;
  localparam logic [DEC_WD-1:0] TACCTL1_OFS = 7'h64;
  localparam logic [DEC_WD-1:0] TACCR1_OFS  = 7'h74;
  localparam logic [DEC_WD-1:0] TAIV_OFS    = 7'h2E;  // Vector sits apart from the rest

  // Writable bits only, flags go their own way
  localparam logic [15:0] TACTL_WMASK  = 16'h03F2;  // TASSEL, ID, MC, TAIE
  localparam logic [15:0] TACCTL_WMASK = 16'h00F4;  // OUTMOD, CCIE, OUT
  localparam int          TACLR_BIT    = 2;         // Self-clearing, never stored

  //////////////////////////////////////////////////////////////////////
  // Mode codes
  //////////////////////////////////////////////////////////////////////
  localparam logic [1:0] MC_STOP   = 2'b00;
  localparam logic [1:0] MC_UP     = 2'b01;  // 0 .. TACCR0
  localparam logic [1:0] MC_CONT   = 2'b10;  // 0 .. FFFF
  localparam logic [1:0] MC_UPDOWN = 2'b11;  // 0 .. TACCR0 .. 0

  localparam logic [1:0] SEL_ACLK  = 2'b01;
  localparam logic [1:0] SEL_SMCLK = 2'b10;

  localparam logic [2:0] OUTMOD_OUT     = 3'd0;
  localparam logic [2:0] OUTMOD_SET     = 3'd1;
  localparam logic [2:0] OUTMOD_TOG_RST = 3'd2;
  localparam logic [2:0] OUTMOD_SET_RST = 3'd3;
  localparam logic [2:0] OUTMOD_TOG     = 3'd4;
  localparam logic [2:0] OUTMOD_RST     = 3'd5;
  localparam logic [2:0] OUTMOD_TOG_SET = 3'd6;
  localparam logic [2:0] OUTMOD_RST_SET = 3'd7;

  localparam logic [3:0] TAIV_NONE  = 4'h0;
  localparam logic [3:0] TAIV_CCR1  = 4'h2;
  localparam logic [3:0] TAIV_TAIFG = 4'hA;

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic        en;    // One-cycle strobe
    logic [13:0] addr;  // Word address
    logic [1:0]  we;    // Byte enables, zero means read
    logic [15:0] din;
  } per_req_t;

  typedef struct packed {
    logic [5:0] rsvd;
    logic [1:0] tassel;
    logic [1:0] id;
    logic [1:0] mc;
    logic       spare;
    logic       taclr;
    logic       taie;
    logic       taifg;
  } tactl_t;

  typedef struct packed {
    logic [7:0] rsvd_hi;   // Old capture fields
    logic [2:0] outmod;
    logic       ccie;
    logic       rsvd_cci;
    logic       out;
    logic       rsvd_cov;
    logic       ccifg;
  } tacctl_t;

  typedef struct packed {
    logic [15:0] tar;
    logic [15:0] tar_nxt;  // Value after the next count pulse
    logic        tar_clk;  // Count pulse
    logic        running;  // Mode is not stop
  } tmr_t;

  typedef struct packed {
    logic cctl_wr;
    logic ccr_wr;
  } ccr_wr_t;

endpackage
